// ==== src/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split: tag | index | byte offset
`define DCACHE_TAG_W    21

// 128 sets
`define DCACHE_INDEX_W  7

// byte offset inside a 16-byte line
`define DCACHE_OFFSET_W 4

// words per line, also the refill burst length
`define DCACHE_WORDS    4

// associativity
`define DCACHE_WAYS     2

`endif

// ==== src/dcache_addr_pkg.sv ====
`include "dcache_macros.svh"

package dcache_addr_pkg;

    // request address fields
    typedef logic [`DCACHE_TAG_W-1:0]    tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]  index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    // word slot within a line
    typedef logic [$clog2(`DCACHE_WORDS)-1:0] word_sel_t;

    // full byte address on the memory side
    typedef logic [`DCACHE_TAG_W+`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1:0] byte_addr_t;

endpackage

// ==== src/dcache_line_pkg.sv ====
`include "dcache_macros.svh"

package dcache_line_pkg;

    // pipe side data
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;

    // one cache line and its byte enables
    typedef logic [`DCACHE_WORDS*32-1:0] line_t;
    typedef logic [`DCACHE_WORDS*4-1:0]  line_strb_t;

    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        // victim chosen, decide on write-back
        ST_MISS      = 3'd2,
        ST_WRITEBACK = 3'd3,
        ST_REFILL    = 3'd4
    } main_state_t;

endpackage

// ==== src/way_ram.sv ====
`include "dcache_macros.svh"

module way_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 1 << `DCACHE_INDEX_W
) (
    input  logic                    clk,
    input  dcache_addr_pkg::index_t addr,
    input  logic                    we,
    input  payload_t                din,
    output payload_t                dout
);

    payload_t mem [depth];

    // single port, registered read
    // a write returns the old contents on dout
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];
    end

endmodule

// ==== src/line_state.sv ====
`include "dcache_macros.svh"

module line_state (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_addr_pkg::index_t lookup_index,
    input  dcache_addr_pkg::index_t set_index,
    input  logic                    fill_we,
    input  dcache_line_pkg::way_t   fill_way,
    input  logic                    fill_dirty,
    input  logic                    refill_done,
    output logic [`DCACHE_WAYS-1:0] valid_bits,
    output dcache_line_pkg::way_t   victim,
    output logic                    victim_dirty
);

    localparam int sets = 1 << `DCACHE_INDEX_W;

    logic [sets-1:0]       valid_q [`DCACHE_WAYS];
    logic [sets-1:0]       dirty_q [`DCACHE_WAYS];
    dcache_line_pkg::way_t victim_q;

    // every fill marks the line valid, dirty only for stores
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else if (fill_we) begin
            valid_q[fill_way][set_index] <= 1'b1;
            dirty_q[fill_way][set_index] <= fill_dirty;
        end
    end

    // round robin, advances once per finished refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_q <= '0;
        end else if (fill_we && refill_done) begin
            victim_q <= victim_q + 1'b1;
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            valid_bits[w] = valid_q[w][lookup_index];
        end
    end

    assign victim       = victim_q;
    assign victim_dirty = valid_q[victim_q][lookup_index] && dirty_q[victim_q][lookup_index];

    a_fill_index_known: assert property (
        @(posedge clk) disable iff (!resetn) fill_we |-> !$isunknown(set_index)
    );

endmodule

// ==== src/refill_buffer.sv ====
`include "dcache_macros.svh"

module refill_buffer (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       refill_start,
    input  dcache_addr_pkg::word_sel_t start_word,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  dcache_line_pkg::word_t     ret_data,
    output dcache_line_pkg::line_t     refill_line,
    output logic                       critical_beat
);

    dcache_line_pkg::line_t     line_q;
    dcache_addr_pkg::word_sel_t slot_q;
    dcache_addr_pkg::word_sel_t beat_q;

    // current beat drops into its slot right away
    always_comb begin
        refill_line = line_q;
        if (ret_valid) begin
            refill_line[slot_q*32 +: 32] = ret_data;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start) begin
            line_q <= '0;
        end else if (ret_valid) begin
            line_q <= refill_line;
        end
    end

    // slot wraps inside the line, beat counts from the requested word
    always_ff @(posedge clk) begin
        if (!resetn) begin
            slot_q <= '0;
            beat_q <= '0;
        end else if (refill_start) begin
            slot_q <= start_word;
            beat_q <= '0;
        end else if (ret_valid) begin
            slot_q <= slot_q + 1'b1;
            beat_q <= beat_q + 1'b1;
        end
    end

    // first beat carries the requested word
    assign critical_beat = ret_valid && (beat_q == '0);

    a_last_on_fourth: assert property (
        @(posedge clk) disable iff (!resetn)
        (ret_valid && ret_last) |-> (beat_q == `DCACHE_WORDS - 1)
    );

endmodule

// ==== src/dcache_ctrl.sv ====
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                         clk,
    input  logic                         resetn,
    // pipe side
    input  logic                         valid,
    input  logic                         write,
    input  dcache_addr_pkg::tag_t        tag,
    input  dcache_addr_pkg::index_t      index,
    input  dcache_addr_pkg::offset_t     offset,
    input  dcache_line_pkg::wstrb_t      wstrb,
    input  dcache_line_pkg::word_t       wdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    output dcache_line_pkg::word_t       rdata,
    // memory side
    input  logic                         rd_rdy,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic                         wr_rdy,
    output logic                         rd_req,
    output dcache_addr_pkg::byte_addr_t  rd_addr,
    output logic                         wr_req,
    output dcache_addr_pkg::byte_addr_t  wr_addr,
    output dcache_line_pkg::line_t       wr_data,
    // tag and data rams
    input  dcache_addr_pkg::tag_t        tag_rd0,
    input  dcache_addr_pkg::tag_t        tag_rd1,
    input  dcache_line_pkg::line_t       line_rd0,
    input  dcache_line_pkg::line_t       line_rd1,
    output dcache_addr_pkg::index_t      ram_index,
    output logic                         ram_we0,
    output logic                         ram_we1,
    output dcache_addr_pkg::tag_t        tag_wr,
    output dcache_line_pkg::line_t       line_wr,
    // valid, dirty and victim
    input  logic [`DCACHE_WAYS-1:0]      valid_bits,
    input  dcache_line_pkg::way_t        victim,
    input  logic                         victim_dirty,
    output dcache_addr_pkg::index_t      set_index,
    output logic                         fill_we,
    output dcache_line_pkg::way_t        fill_way,
    output logic                         fill_dirty,
    output dcache_addr_pkg::index_t      lookup_index,
    // refill buffer
    output logic                         refill_start,
    output dcache_addr_pkg::word_sel_t   start_word,
    input  dcache_line_pkg::line_t       refill_line,
    input  logic                         critical_beat
);

    dcache_line_pkg::main_state_t state_reg;
    dcache_line_pkg::main_state_t state_next;

    logic                       write_reg;
    dcache_addr_pkg::tag_t      tag_reg;
    dcache_addr_pkg::index_t    index_reg;
    dcache_addr_pkg::word_sel_t word_reg;
    dcache_line_pkg::wstrb_t    wstrb_reg;
    dcache_line_pkg::word_t     wdata_reg;
    logic                       rd_sent_reg;

    logic accept, idle, lookup, refill;
    logic hit0, hit1, hit, hit_write, refill_write;
    dcache_addr_pkg::tag_t      victim_tag;
    dcache_line_pkg::line_t     hit_line, base_line, merge_data;
    dcache_line_pkg::line_strb_t merge_strb;

    assign idle   = (state_reg == dcache_line_pkg::ST_IDLE);
    assign lookup = (state_reg == dcache_line_pkg::ST_LOOKUP);
    assign refill = (state_reg == dcache_line_pkg::ST_REFILL);

    // a read hit may overlap with the next request
    assign addr_ok = idle || (lookup && hit && !write_reg);
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            write_reg <= write;
            tag_reg   <= tag;
            index_reg <= index;
            word_reg  <= offset[`DCACHE_OFFSET_W-1:2];
            wstrb_reg <= wstrb;
            wdata_reg <= wdata;
        end
    end

    // tags and lines come back from the rams in the lookup cycle
    assign hit0     = valid_bits[0] && (tag_rd0 == tag_reg);
    assign hit1     = valid_bits[1] && (tag_rd1 == tag_reg);
    assign hit      = hit0 || hit1;
    assign hit_line = hit1 ? line_rd1 : line_rd0;

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            dcache_line_pkg::ST_IDLE: begin
                if (accept) begin
                    state_next = dcache_line_pkg::ST_LOOKUP;
                end
            end
            dcache_line_pkg::ST_LOOKUP: begin
                if (!hit) begin
                    state_next = dcache_line_pkg::ST_MISS;
                end else if (!accept) begin
                    state_next = dcache_line_pkg::ST_IDLE;
                end
            end
            dcache_line_pkg::ST_MISS: begin
                state_next = victim_dirty ? dcache_line_pkg::ST_WRITEBACK
                                          : dcache_line_pkg::ST_REFILL;
            end
            dcache_line_pkg::ST_WRITEBACK: begin
                if (wr_rdy) begin
                    state_next = dcache_line_pkg::ST_REFILL;
                end
            end
            dcache_line_pkg::ST_REFILL: begin
                if (refill_write) begin
                    state_next = dcache_line_pkg::ST_IDLE;
                end
            end
            default: state_next = dcache_line_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_reg <= dcache_line_pkg::ST_IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    // stores answer at once, read misses on the critical beat
    assign data_ok = (lookup && (write_reg || hit)) || (refill && critical_beat && !write_reg);

    // refill_line already holds the requested word on the critical beat
    assign base_line = refill ? refill_line : hit_line;
    assign rdata     = base_line[word_reg*32 +: 32];

    // store merge over the hit line or the refilled line
    assign merge_strb = write_reg ? dcache_line_pkg::line_strb_t'(wstrb_reg) << (word_reg*4) : '0;
    assign merge_data = dcache_line_pkg::line_t'(wdata_reg) << (word_reg*32);

    always_comb begin
        for (int b = 0; b < `DCACHE_WORDS*4; b++) begin
            line_wr[b*8 +: 8] = merge_strb[b] ? merge_data[b*8 +: 8] : base_line[b*8 +: 8];
        end
    end

    assign hit_write    = lookup && write_reg && hit;
    assign refill_write = refill && ret_valid && ret_last;

    assign fill_we      = hit_write || refill_write;
    assign fill_way     = refill ? victim : dcache_line_pkg::way_t'(hit1);
    assign fill_dirty   = write_reg;
    assign ram_we0      = fill_we && (fill_way == 1'b0);
    assign ram_we1      = fill_we && (fill_way == 1'b1);
    assign tag_wr       = tag_reg;
    assign ram_index    = accept ? index : index_reg;
    assign set_index    = index_reg;
    assign lookup_index = index_reg;

    assign refill_start = (state_reg == dcache_line_pkg::ST_MISS);
    assign start_word   = word_reg;

    // rams still hold index_reg while the victim is written back
    assign victim_tag = (victim == 1'b1) ? tag_rd1 : tag_rd0;
    assign wr_req     = (state_reg == dcache_line_pkg::ST_WRITEBACK);
    assign wr_addr    = {victim_tag, index_reg, {`DCACHE_OFFSET_W{1'b0}}};
    assign wr_data    = (victim == 1'b1) ? line_rd1 : line_rd0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_sent_reg <= 1'b0;
        end else if (!refill) begin
            rd_sent_reg <= 1'b0;
        end else if (rd_rdy) begin
            rd_sent_reg <= 1'b1;
        end
    end

    assign rd_req  = refill && !rd_sent_reg;
    assign rd_addr = {tag_reg, index_reg, word_reg, 2'b00};

    a_one_bus_req: assert property (
        @(posedge clk) disable iff (!resetn) !(rd_req && wr_req)
    );

    a_no_data_ok_in_miss: assert property (
        @(posedge clk) disable iff (!resetn)
        (state_reg inside {dcache_line_pkg::ST_MISS, dcache_line_pkg::ST_WRITEBACK}) |-> !data_ok
    );

endmodule

// ==== src/dcache.sv ====
`include "dcache_macros.svh"

module dcache (
    input  logic                        clk,
    input  logic                        resetn,
    // pipe side
    input  logic                        valid,
    input  logic                        write,
    input  dcache_addr_pkg::tag_t       tag,
    input  dcache_addr_pkg::index_t     index,
    input  dcache_addr_pkg::offset_t    offset,
    input  dcache_line_pkg::wstrb_t     wstrb,
    input  dcache_line_pkg::word_t      wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output dcache_line_pkg::word_t      rdata,
    // memory read channel
    output logic                        rd_req,
    output dcache_addr_pkg::byte_addr_t rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  dcache_line_pkg::word_t      ret_data,
    // memory write channel
    output logic                        wr_req,
    output dcache_addr_pkg::byte_addr_t wr_addr,
    output dcache_line_pkg::line_t      wr_data,
    input  logic                        wr_rdy
);

    dcache_addr_pkg::tag_t      tag_rd0, tag_rd1, tag_wr;
    dcache_line_pkg::line_t     line_rd0, line_rd1, line_wr;
    dcache_addr_pkg::index_t    ram_index, set_index, lookup_index;
    logic                       ram_we0, ram_we1;
    logic [`DCACHE_WAYS-1:0]    valid_bits;
    dcache_line_pkg::way_t      victim, fill_way;
    logic                       victim_dirty, fill_we, fill_dirty;
    logic                       refill_start, critical_beat;
    dcache_addr_pkg::word_sel_t start_word;
    dcache_line_pkg::line_t     refill_line;

    dcache_ctrl u_ctrl (.*);

    // the last beat of a burst closes the refill
    line_state u_line_state (
        .clk, .resetn, .lookup_index, .set_index, .fill_we, .fill_way, .fill_dirty,
        .refill_done (ret_last),
        .valid_bits, .victim, .victim_dirty
    );

    refill_buffer u_refill_buffer (
        .clk, .resetn, .refill_start, .start_word, .ret_valid, .ret_last, .ret_data,
        .refill_line, .critical_beat
    );

    way_ram #(.payload_t(dcache_addr_pkg::tag_t)) u_tag_way0 (
        .clk, .addr(ram_index), .we(ram_we0), .din(tag_wr), .dout(tag_rd0)
    );

    way_ram #(.payload_t(dcache_addr_pkg::tag_t)) u_tag_way1 (
        .clk, .addr(ram_index), .we(ram_we1), .din(tag_wr), .dout(tag_rd1)
    );

    way_ram #(.payload_t(dcache_line_pkg::line_t)) u_data_way0 (
        .clk, .addr(ram_index), .we(ram_we0), .din(line_wr), .dout(line_rd0)
    );

    way_ram #(.payload_t(dcache_line_pkg::line_t)) u_data_way1 (
        .clk, .addr(ram_index), .we(ram_we1), .din(line_wr), .dout(line_rd1)
    );

endmodule

// ==== testbench/tb_dcache.sv ====
`include "dcache_macros.svh"

module tb_dcache;

    localparam int reset_cycles = 10;
    localparam int random_reqs  = 300;

    logic                           clk;
    logic                           resetn;
    logic                           valid;
    logic                           write;
    dcache_addr_pkg::tag_t          tag;
    dcache_addr_pkg::index_t        index;
    dcache_addr_pkg::offset_t       offset;
    dcache_line_pkg::wstrb_t        wstrb;
    dcache_line_pkg::word_t         wdata;
    logic                           addr_ok;
    logic                           data_ok;
    dcache_line_pkg::word_t         rdata;
    logic                           rd_req;
    dcache_addr_pkg::byte_addr_t    rd_addr;
    logic                           rd_rdy;
    logic                           ret_valid;
    logic                           ret_last;
    dcache_line_pkg::word_t         ret_data;
    logic                           wr_req;
    dcache_addr_pkg::byte_addr_t    wr_addr;
    dcache_line_pkg::line_t         wr_data;
    logic                           wr_rdy;

    // lfsr state and run bookkeeping
    logic [31:0] lfsr = 32'h5ac30dfc;
    int          cycle = 0;
    int          limit = 0;
    int          total_reqs = 0;
    int          done_count = 0;
    int          mismatches = 0;
    int          failures = 0;

    // planned requests not yet driven
    logic                        plan_write [$];
    dcache_addr_pkg::byte_addr_t plan_addr [$];
    dcache_line_pkg::wstrb_t     plan_strb [$];
    dcache_line_pkg::word_t      plan_data [$];

    // accepted requests waiting for data_ok
    logic                        exp_write [$];
    dcache_line_pkg::word_t      exp_data [$];
    int                          exp_cycle [$];

    dcache_line_pkg::word_t      model [dcache_addr_pkg::byte_addr_t];
    dcache_line_pkg::word_t      mem [dcache_addr_pkg::byte_addr_t];
    dcache_addr_pkg::byte_addr_t last_addr;
    dcache_addr_pkg::byte_addr_t burst_base;
    logic                        rd_active = 1'b0;
    int                          beat_k = 0;

    dcache u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h80200003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    // never-written memory content hashed from the whole address
    function automatic dcache_line_pkg::word_t init_word(input dcache_addr_pkg::byte_addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h00c0ffee;
    endfunction

    function automatic dcache_line_pkg::word_t model_word(input dcache_addr_pkg::byte_addr_t a);
        dcache_addr_pkg::byte_addr_t k;
        k = {a[31:2], 2'b00};
        return model.exists(k) ? model[k] : init_word(k);
    endfunction

    function automatic dcache_line_pkg::word_t mem_word(input dcache_addr_pkg::byte_addr_t a);
        dcache_addr_pkg::byte_addr_t k;
        k = {a[31:2], 2'b00};
        return mem.exists(k) ? mem[k] : init_word(k);
    endfunction

    task automatic check_word(input string name, input dcache_line_pkg::word_t got,
                              input dcache_line_pkg::word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input dcache_line_pkg::line_t got,
                              input dcache_line_pkg::line_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input dcache_addr_pkg::byte_addr_t got,
                              input dcache_addr_pkg::byte_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic add_req(input logic w, input dcache_addr_pkg::byte_addr_t a,
                           input dcache_line_pkg::wstrb_t s, input dcache_line_pkg::word_t d);
        plan_write.push_back(w);
        plan_addr.push_back(a);
        plan_strb.push_back(s);
        plan_data.push_back(d);
        total_reqs++;
    endtask

    // byte merge into the flat model
    task automatic model_store(input dcache_addr_pkg::byte_addr_t a,
                               input dcache_line_pkg::wstrb_t s, input dcache_line_pkg::word_t d);
        dcache_line_pkg::word_t w;
        w = model_word(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        model[{a[31:2], 2'b00}] = w;
    endtask

    task automatic take_data_ok();
        if (data_ok) begin
            if (exp_write.size() == 0) begin
                failures++;
                $display("data_ok pulsed with no request outstanding at cycle %0d", cycle);
            end else begin
                if (exp_write[0]) begin
                    if (cycle != exp_cycle[0] + 1) begin
                        failures++;
                        $display("write data_ok came %0d cycles after acceptance",
                                 cycle - exp_cycle[0]);
                    end
                end else begin
                    check_word("rdata", rdata, exp_data[0]);
                end
                void'(exp_write.pop_front());
                void'(exp_data.pop_front());
                void'(exp_cycle.pop_front());
                done_count++;
            end
        end
    endtask

    task automatic take_accept();
        dcache_addr_pkg::byte_addr_t a;
        if (valid && addr_ok) begin
            a = {tag, index, offset};
            exp_write.push_back(write);
            exp_data.push_back(model_word(a));
            exp_cycle.push_back(cycle);
            if (write) begin
                model_store(a, wstrb, wdata);
            end
            last_addr = a;
        end
    endtask

    // hold a request until accepted, then maybe start the next one
    task automatic drive_request();
        dcache_addr_pkg::byte_addr_t a;
        if (!valid || addr_ok) begin
            if (plan_write.size() != 0 && rand_bits(2) != 0) begin
                a = plan_addr.pop_front();
                valid  <= 1'b1;
                write  <= plan_write.pop_front();
                wstrb  <= plan_strb.pop_front();
                wdata  <= plan_data.pop_front();
                tag    <= a[31 -: `DCACHE_TAG_W];
                index  <= a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
                offset <= a[`DCACHE_OFFSET_W-1:0];
            end else begin
                valid <= 1'b0;
            end
        end
    endtask

    // read channel returns a wrapped burst from the requested word
    task automatic serve_read();
        logic [1:0] slot;
        if (rd_req && rd_rdy) begin
            check_addr("rd_addr", rd_addr, {last_addr[31:2], 2'b00});
            burst_base = rd_addr;
            beat_k     = 0;
            rd_active  = 1'b1;
        end
        rd_rdy <= rand_bits(1);
        if (rd_active && rand_bits(2) != 0) begin
            slot = burst_base[3:2] + 2'(beat_k);
            ret_valid <= 1'b1;
            ret_data  <= mem_word({burst_base[31:4], slot, 2'b00});
            ret_last  <= (beat_k == 3);
            beat_k++;
            if (beat_k == 4) begin
                rd_active = 1'b0;
            end
        end else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
        end
    endtask

    task automatic serve_write();
        dcache_line_pkg::line_t exp;
        dcache_addr_pkg::byte_addr_t base;
        if (wr_req && wr_rdy) begin
            base = {wr_addr[31:4], 4'h0};
            check_addr("wr_addr", wr_addr, base);
            for (int w = 0; w < `DCACHE_WORDS; w++) begin
                exp[w*32 +: 32] = model_word(base + 32'(w * 4));
                mem[base + 32'(w * 4)] = wr_data[w*32 +: 32];
            end
            check_line("wr_data", wr_data, exp);
        end
        wr_rdy <= rand_bits(1);
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            cycle = cycle + 1;
            take_data_ok();
            take_accept();
            drive_request();
            serve_read();
            serve_write();
        end
    end

    initial begin
        wait (limit != 0 && cycle > limit);
        $display("timeout: %0d of %0d requests answered after %0d cycles",
                 done_count, total_reqs, cycle);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        dcache_addr_pkg::byte_addr_t a;
        dcache_addr_pkg::tag_t       tag_pool [4];
        dcache_addr_pkg::index_t     idx_pool [2];
        dcache_line_pkg::wstrb_t     s;
        logic                        is_write;
        dcache_line_pkg::word_t      data;
        resetn    = 1'b0;
        valid     = 1'b0;
        write     = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        tag_pool  = '{21'h00012, 21'h0a5a5, 21'h13001, 21'h1fffe};
        idx_pool  = '{7'h05, 7'h4c};

        // dirty line, two hits, then three tags in one set
        add_req(1'b1, {tag_pool[0], idx_pool[0], 4'h4}, 4'b0110, 32'h11223344);
        add_req(1'b0, {tag_pool[0], idx_pool[0], 4'h4}, 4'h0, 32'h0);
        add_req(1'b0, {tag_pool[0], idx_pool[0], 4'h4}, 4'h0, 32'h0);
        add_req(1'b0, {tag_pool[1], idx_pool[0], 4'h8}, 4'h0, 32'h0);
        add_req(1'b0, {tag_pool[2], idx_pool[0], 4'hc}, 4'h0, 32'h0);
        add_req(1'b0, {tag_pool[0], idx_pool[0], 4'h0}, 4'h0, 32'h0);
        add_req(1'b0, {tag_pool[0], idx_pool[0], 4'h4}, 4'h0, 32'h0);

        for (int i = 0; i < random_reqs; i++) begin
            a[31 -: `DCACHE_TAG_W]                 = tag_pool[rand_bits(2)];
            a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W] = idx_pool[rand_bits(1)];
            a[`DCACHE_OFFSET_W-1:0]                = {2'(rand_bits(2)), 2'b00};
            s = rand_bits(4);
            if (s == 4'h0) begin
                s = 4'hf;
            end
            is_write = (rand_bits(2) == 0);
            data     = rand_bits(32);
            add_req(is_write, a, s, data);
        end
        limit = 40 * total_reqs + reset_cycles;

        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_word("addr_ok", 32'(addr_ok), 32'h1);
        check_word("data_ok", 32'(data_ok), 32'h0);
        check_word("rd_req", 32'(rd_req), 32'h0);
        check_word("wr_req", 32'(wr_req), 32'h0);

        wait (done_count == total_reqs);
        @(negedge clk);
        while (!(addr_ok && !rd_req && !wr_req && !rd_active)) begin
            @(negedge clk);
        end

        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
src/dcache_addr_pkg.sv
src/dcache_line_pkg.sv
src/way_ram.sv
src/line_state.sv
src/refill_buffer.sv
src/dcache_ctrl.sv
src/dcache.sv
testbench/tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_dcache -o sim_dcache
./obj_dir/sim_dcache > sim.log || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi
